/* Makefile */
TOP := tb_posit_noncomp

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f \
		--top-module $(TOP) -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir

/* bench/tb_posit_noncomp.sv */
`timescale 1ns/1ps
`include "posit_defines.svh"

module tb_posit_noncomp;

  localparam int RAND_COUNT   = 200;
  localparam int EXTRA_COUNT  = 3;  // Flush pair and the latency probe
  localparam int READY_HIGH   = 0;
  localparam int READY_RANDOM = 1;
  localparam int READY_LOW    = 2;

  localparam logic [`POSIT_WIDTH-1:0] P_ZERO = '0;
  localparam logic [`POSIT_WIDTH-1:0] P_ONE  = 32'h4000_0000;
  localparam logic [`POSIT_WIDTH-1:0] P_MONE = 32'hC000_0000;
  localparam logic [`POSIT_WIDTH-1:0] P_NAR  = `POSIT_NAR;
  localparam logic [`POSIT_WIDTH-1:0] P_TRUE = 32'h0000_0001;

  typedef struct packed {
    logic [1:0]              op;
    logic [2:0]              rnd;
    logic [1:0]              sgnj;
    logic [`POSIT_WIDTH-1:0] a;
    logic [`POSIT_WIDTH-1:0] b;
    logic [`POSIT_WIDTH-1:0] result;
    logic                    nv;
  } vector_t;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 flush;
  posit_pkg::request_t  req;
  logic                 in_valid;
  logic                 in_ready;
  posit_pkg::response_t rsp;
  logic                 out_valid;
  logic                 out_ready = 1'b1;
  logic                 busy;

  vector_t              vectors[$];
  posit_pkg::response_t exp_q[$];
  int                   stamp_q[$];  // Acceptance cycle of each owed response
  posit_pkg::response_t exp_drv;     // Expected answer to the request on req
  posit_pkg::response_t held_rsp;
  logic                 stall_armed = 1'b0;
  logic                 check_latency;
  int                   ready_mode;
  int                   cycles = 0;
  int                   max_cycles = 0;
  logic [31:0]          stim_state = 32'd59;
  logic [31:0]          ready_state = 32'd59;

  posit_noncomp u_dut (
    .clk_i       (clk),
    .rst_i       (rst),
    .flush_i     (flush),
    .req_i       (req),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .rsp_o       (rsp),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .busy_o      (busy)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Halves swapped since the low LCG bits repeat quickly
  function automatic logic [31:0] rand_word();
    stim_state = lcg_step(stim_state);
    return {stim_state[15:0], stim_state[31:16]};
  endfunction

  function automatic logic [31:0] pick_operand();
    logic [31:0] x;
    x = rand_word();
    case (x[2:0])
      3'd0:    return P_ZERO;
      3'd1:    return P_NAR;
      3'd2:    return P_ONE;
      3'd3:    return P_MONE;
      default: return rand_word();
    endcase
  endfunction

  function automatic posit_pkg::request_t random_request();
    posit_pkg::request_t r;
    logic [31:0]         x;
    logic [1:0]          legal_rnd;
    x           = rand_word();
    legal_rnd   = (x[6:5] == 2'd3) ? 2'd1 : x[6:5];
    r.a         = pick_operand();
    r.b         = pick_operand();
    r.op        = posit_pkg::operation_e'(x[1:0]);
    r.rnd_mode  = posit_pkg::roundmode_e'(x[4] ? x[7:5] : {1'b0, legal_rnd});
    r.sgnj_mode = posit_pkg::signinject_e'(x[9:8]);
    return r;
  endfunction

  // Expected response straight from the posit rules
  function automatic posit_pkg::response_t model_response(input posit_pkg::request_t r);
    logic [`POSIT_WIDTH-1:0] a;
    logic [`POSIT_WIDTH-1:0] b;
    logic                    a_nar;
    logic                    b_nar;
    logic                    less;
    logic                    want_sign;
    logic                    illegal;
    posit_pkg::response_t    e;
    a         = r.a;
    b         = r.b;
    a_nar     = (a == P_NAR);
    b_nar     = (b == P_NAR);
    less      = ($signed(a) < $signed(b));  // Posit order is integer order
    want_sign = 1'b0;
    illegal   = 1'b0;
    e         = '0;
    case (r.op)
      posit_pkg::CMP: begin
        e.status.nv = a_nar || b_nar;
        case (r.rnd_mode)
          posit_pkg::RNE: e.result[0] = !(a_nar || b_nar) && (less || a == b);
          posit_pkg::RTZ: e.result[0] = !(a_nar || b_nar) && less;
          posit_pkg::RDN: e.result[0] = !(a_nar || b_nar) && (a == b);
          default:        illegal = 1'b1;
        endcase
      end
      posit_pkg::SGNJ: begin
        case (r.sgnj_mode)
          posit_pkg::SI_SGNJ:  want_sign = b[`POSIT_WIDTH-1];
          posit_pkg::SI_SGNJN: want_sign = !b[`POSIT_WIDTH-1];
          posit_pkg::SI_SGNJX: want_sign = a[`POSIT_WIDTH-1] ^ b[`POSIT_WIDTH-1];
          default:             illegal = 1'b1;
        endcase
        e.result = (a[`POSIT_WIDTH-1] == want_sign) ? a : -a;  // Negation keeps 0 and NaR
      end
      posit_pkg::MINMAX: begin
        e.status.nv = a_nar || b_nar;
        if (r.rnd_mode != posit_pkg::RNE && r.rnd_mode != posit_pkg::RTZ) begin
          illegal = 1'b1;
        end else if (a_nar) begin
          e.result = b;  // Also NaR when both are
        end else if (b_nar) begin
          e.result = a;
        end else if (r.rnd_mode == posit_pkg::RNE) begin
          e.result = less ? b : a;
        end else begin
          e.result = less ? a : b;
        end
      end
      default: illegal = 1'b1;
    endcase
    if (illegal) begin
      e           = '0;
      e.status.nv = 1'b1;
    end
    return e;
  endfunction

  task automatic fail_run();
    $display("Result: FAILED");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("[ERROR] %0t ns: %s expected %0h, actual %0h", $time, name, expected, actual);
    fail_run();
  endtask

  task automatic add_vector(input logic [1:0] op, input logic [2:0] rnd, input logic [1:0] sgnj,
                            input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] result, input logic nv);
    vectors.push_back('{op, rnd, sgnj, a, b, result, nv});
  endtask

  task automatic build_table();
    // CMP with RNE as a <= b, RTZ as a < b and RDN as a == b
    add_vector(2'd0, 3'd0, 2'd0, 32'hFFFF_FFFF, 32'h0000_0001, P_TRUE, 1'b0);
    add_vector(2'd0, 3'd0, 2'd0, P_ONE, P_ONE, P_TRUE, 1'b0);
    add_vector(2'd0, 3'd0, 2'd0, P_ONE, P_MONE, P_ZERO, 1'b0);
    add_vector(2'd0, 3'd1, 2'd0, P_MONE, P_ONE, P_TRUE, 1'b0);
    add_vector(2'd0, 3'd1, 2'd0, P_ONE, P_ONE, P_ZERO, 1'b0);
    add_vector(2'd0, 3'd1, 2'd0, P_ZERO, 32'h0000_0001, P_TRUE, 1'b0);
    add_vector(2'd0, 3'd2, 2'd0, P_ZERO, P_ZERO, P_TRUE, 1'b0);
    add_vector(2'd0, 3'd2, 2'd0, P_MONE, P_ONE, P_ZERO, 1'b0);
    add_vector(2'd0, 3'd0, 2'd0, P_NAR, P_ZERO, P_ZERO, 1'b1);
    add_vector(2'd0, 3'd2, 2'd0, P_NAR, P_NAR, P_ZERO, 1'b1);
    // Sign inject modes 0 SGNJ, 1 SGNJN, 2 SGNJX
    add_vector(2'd1, 3'd0, 2'd0, P_ONE, P_MONE, P_MONE, 1'b0);
    add_vector(2'd1, 3'd0, 2'd0, P_MONE, P_ONE, P_ONE, 1'b0);
    add_vector(2'd1, 3'd0, 2'd1, P_ONE, P_ONE, P_MONE, 1'b0);
    add_vector(2'd1, 3'd0, 2'd1, 32'h3000_0000, P_MONE, 32'h3000_0000, 1'b0);
    add_vector(2'd1, 3'd0, 2'd2, P_MONE, P_MONE, P_ONE, 1'b0);
    add_vector(2'd1, 3'd0, 2'd2, 32'h2000_0000, 32'h8000_0001, 32'hE000_0000, 1'b0);
    add_vector(2'd1, 3'd0, 2'd1, P_ZERO, P_ZERO, P_ZERO, 1'b0);
    add_vector(2'd1, 3'd0, 2'd0, P_NAR, P_ZERO, P_NAR, 1'b0);
    // MINMAX gives max under RNE and min under RTZ
    add_vector(2'd2, 3'd0, 2'd0, P_MONE, P_ONE, P_ONE, 1'b0);
    add_vector(2'd2, 3'd1, 2'd0, P_MONE, P_ONE, P_MONE, 1'b0);
    add_vector(2'd2, 3'd0, 2'd0, P_NAR, P_MONE, P_MONE, 1'b1);
    add_vector(2'd2, 3'd1, 2'd0, P_ONE, P_NAR, P_ONE, 1'b1);
    add_vector(2'd2, 3'd1, 2'd0, P_NAR, P_NAR, P_NAR, 1'b1);
    // Unused op and illegal modes
    add_vector(2'd3, 3'd0, 2'd0, P_ONE, P_ONE, P_ZERO, 1'b1);
    add_vector(2'd0, 3'd3, 2'd0, P_ONE, P_ONE, P_ZERO, 1'b1);
    add_vector(2'd1, 3'd0, 2'd3, P_ONE, P_MONE, P_ZERO, 1'b1);
    add_vector(2'd2, 3'd4, 2'd0, P_ONE, P_MONE, P_ZERO, 1'b1);
  endtask

  // Entered on a falling edge and left on the falling edge after acceptance
  task automatic send(input posit_pkg::request_t r, input posit_pkg::response_t e);
    req      = r;
    exp_drv  = e;
    in_valid = 1'b1;
    @(posedge clk);
    while (!in_ready) begin
      @(posedge clk);
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic change_ready(input int mode);
    ready_mode = mode;
    @(negedge clk);
  endtask

  always @(negedge clk) begin
    ready_state = lcg_step(ready_state);
    case (ready_mode)
      READY_RANDOM: out_ready = ready_state[20];
      READY_LOW:    out_ready = 1'b0;
      default:      out_ready = 1'b1;
    endcase
  end

  // Scoreboard sampled on the rising edge before the registers update
  always @(posedge clk) begin
    posit_pkg::response_t head;
    int                   stamp;
    if (!rst) begin
      cycles = cycles + 1;
      if (cycles > max_cycles) begin
        $display("Timeout after %0d cycles with %0d responses still owed", cycles, exp_q.size());
        fail_run();
      end
      assert (busy == (exp_q.size() != 0))
        else report_mismatch("busy_o", 64'(exp_q.size() != 0), 64'(busy));
      assert (in_ready == (exp_q.size() < 2 || out_ready))
        else report_mismatch("in_ready_o", 64'(exp_q.size() < 2 || out_ready), 64'(in_ready));
      if (stall_armed) begin
        assert (out_valid) else report_mismatch("out_valid_o", 64'(1), 64'(out_valid));
        assert (rsp == held_rsp) else report_mismatch("rsp_o", 64'(held_rsp), 64'(rsp));
      end
      stall_armed = out_valid && !out_ready && !flush;
      held_rsp    = rsp;
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("A response came out with no request outstanding");
          fail_run();
        end
        head  = exp_q.pop_front();
        stamp = stamp_q.pop_front();
        assert (rsp.result == head.result)
          else report_mismatch("rsp_o.result", 64'(head.result), 64'(rsp.result));
        assert (rsp.status == head.status)
          else report_mismatch("rsp_o.status", 64'(head.status), 64'(rsp.status));
        if (check_latency) begin
          assert (cycles - stamp == 2)
            else report_mismatch("response latency", 64'(2), 64'(cycles - stamp));
        end
      end
      if (flush) begin
        exp_q.delete();  // Everything in flight is dropped
        stamp_q.delete();
      end else if (in_valid && in_ready) begin
        exp_q.push_back(exp_drv);
        stamp_q.push_back(cycles);
      end
    end
  end

  initial begin
    posit_pkg::request_t  r;
    posit_pkg::response_t e;
    rst           = 1'b1;
    flush         = 1'b0;
    in_valid      = 1'b0;
    req           = '0;
    exp_drv       = '0;
    check_latency = 1'b0;
    ready_mode    = READY_HIGH;
    build_table();
    max_cycles = 8 * (vectors.size() + RAND_COUNT + EXTRA_COUNT) + 50;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    foreach (vectors[i]) begin
      r.a         = vectors[i].a;
      r.b         = vectors[i].b;
      r.op        = posit_pkg::operation_e'(vectors[i].op);
      r.rnd_mode  = posit_pkg::roundmode_e'(vectors[i].rnd);
      r.sgnj_mode = posit_pkg::signinject_e'(vectors[i].sgnj);
      e           = '0;
      e.result    = vectors[i].result;
      e.status.nv = vectors[i].nv;
      assert (model_response(r) == e) else begin
        $display("Reference model disagrees with table entry %0d", i);
        fail_run();
      end
      send(r, e);
    end
    wait_drain();

    change_ready(READY_RANDOM);
    repeat (RAND_COUNT) begin
      r = random_request();
      send(r, model_response(r));
    end
    wait_drain();

    // Both stages filled behind a stalled output and then flushed
    change_ready(READY_LOW);
    repeat (2) begin
      r = random_request();
      send(r, model_response(r));
    end
    assert (!in_ready) else report_mismatch("in_ready_o", 64'(0), 64'(in_ready));
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    assert (!busy) else report_mismatch("busy_o", 64'(0), 64'(busy));
    assert (!out_valid) else report_mismatch("out_valid_o", 64'(0), 64'(out_valid));

    change_ready(READY_HIGH);
    check_latency = 1'b1;
    r = random_request();
    send(r, model_response(r));
    wait_drain();
    check_latency = 1'b0;

    $display("Result: PASSED");
    $finish;
  end

endmodule

/* source/posit_decode.sv */
`timescale 1ns/1ps
`include "posit_defines.svh"

module posit_decode (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 flush_i,
  input  posit_pkg::request_t  req_i,
  input  logic                 valid_i,
  input  logic                 advance_i,
  output posit_pkg::decoded_t  dec_o,
  output logic                 valid_o
);

  posit_pkg::decoded_t dec_d;
  posit_pkg::decoded_t dec_q;
  logic                valid_q;

  // Op and modifier fields into variant bits
  always_comb begin
    dec_d         = '0;
    dec_d.a       = req_i.a;
    dec_d.b       = req_i.b;
    dec_d.nar_a   = (req_i.a.ordinal == `POSIT_NAR);
    dec_d.nar_b   = (req_i.b.ordinal == `POSIT_NAR);

    case (req_i.op)
      posit_pkg::CMP: begin
        case (req_i.rnd_mode)
          posit_pkg::RNE: dec_d.sel.le = 1'b1;
          posit_pkg::RTZ: dec_d.sel.lt = 1'b1;
          posit_pkg::RDN: dec_d.sel.eq = 1'b1;
          default:        dec_d.illegal = 1'b1;
        endcase
      end
      posit_pkg::SGNJ: begin
        // Sign-inject field picks the variant, rounding mode is ignored
        case (req_i.sgnj_mode)
          posit_pkg::SI_SGNJ:  dec_d.sel.sgnj  = 1'b1;
          posit_pkg::SI_SGNJN: dec_d.sel.sgnjn = 1'b1;
          posit_pkg::SI_SGNJX: dec_d.sel.sgnjx = 1'b1;
          default:             dec_d.illegal   = 1'b1;
        endcase
      end
      posit_pkg::MINMAX: begin
        case (req_i.rnd_mode)
          posit_pkg::RNE: dec_d.sel.max = 1'b1;
          posit_pkg::RTZ: dec_d.sel.min = 1'b1;
          default:        dec_d.illegal = 1'b1;
        endcase
      end
      default: dec_d.illegal = 1'b1;  // Unused op code
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (advance_i) begin
      valid_q <= valid_i;  // Empties when nothing new arrives
    end
  end

  // Payload only moves with a real item
  always_ff @(posedge clk_i) begin
    if (advance_i && valid_i) begin
      dec_q <= dec_d;
    end
  end

  assign dec_o   = dec_q;
  assign valid_o = valid_q;

  // A flush cycle must leave the stage empty, even if a request was taken
  a_flush_empties : assert property (
    @(posedge clk_i) disable iff (rst_i)
    flush_i |=> !valid_o
  );

endmodule

/* source/posit_defines.svh */
`ifndef POSIT_DEFINES_SVH
`define POSIT_DEFINES_SVH

// Operand and result width in bits
`define POSIT_WIDTH 32

// Not-a-Real is the sign bit alone
`define POSIT_NAR {1'b1, {(`POSIT_WIDTH-1){1'b0}}}

// All-zero word, also the false result of a compare
`define POSIT_ZERO {`POSIT_WIDTH{1'b0}}

// Integer one in the result word, true result of a compare
`define POSIT_TRUE {{(`POSIT_WIDTH-1){1'b0}}, 1'b1}

`endif

/* source/posit_execute.sv */
`timescale 1ns/1ps
`include "posit_defines.svh"

module posit_execute (
  input  posit_pkg::decoded_t  dec_i,
  output posit_pkg::response_t rsp_o
);

  posit_pkg::variant_t     sel;
  logic                    any_nar;
  logic                    a_lt_b;
  logic                    a_eq_b;
  logic                    cmp_true;
  logic [`POSIT_WIDTH-1:0] cmp_word;
  logic [`POSIT_WIDTH-1:0] minmax_word;
  logic [`POSIT_WIDTH-1:0] sgnj_word;
  logic                    target_sign;
  posit_pkg::posit_u       neg_a;

  assign sel     = dec_i.sel;
  assign any_nar = dec_i.nar_a | dec_i.nar_b;

  // Posit order is plain signed integer order
  assign a_lt_b = (dec_i.a.ordinal < dec_i.b.ordinal);
  assign a_eq_b = (dec_i.a.ordinal == dec_i.b.ordinal);

  assign cmp_true = (sel.lt & a_lt_b)
                  | (sel.le & (a_lt_b | a_eq_b))
                  | (sel.eq & a_eq_b);

  assign cmp_word = (cmp_true && !any_nar) ? `POSIT_TRUE : `POSIT_ZERO;

  always_comb begin
    if (dec_i.nar_a && dec_i.nar_b) begin
      minmax_word = `POSIT_NAR;
    end else if (dec_i.nar_a) begin
      minmax_word = dec_i.b;  // Only b is a real number
    end else if (dec_i.nar_b) begin
      minmax_word = dec_i.a;
    end else if (sel.max) begin
      minmax_word = a_lt_b ? dec_i.b : dec_i.a;
    end else begin
      minmax_word = a_lt_b ? dec_i.a : dec_i.b;
    end
  end

  // Sign bit wanted for the result
  always_comb begin
    if (sel.sgnjn) begin
      target_sign = ~dec_i.b.fields.sign;
    end else if (sel.sgnjx) begin
      target_sign = dec_i.a.fields.sign ^ dec_i.b.fields.sign;
    end else begin
      target_sign = dec_i.b.fields.sign;
    end
  end

  // Two's complement split into sign and body.
  // The carry into the sign only appears for a zero body, so zero and NaR map to themselves
  always_comb begin
    neg_a.fields.body = -dec_i.a.fields.body;
    neg_a.fields.sign = dec_i.a.fields.sign ^ (|dec_i.a.fields.body);
  end

  assign sgnj_word = (dec_i.a.fields.sign == target_sign) ? dec_i.a : neg_a;

  always_comb begin
    rsp_o = '0;  // dz, of, uf, nx never raised
    if (dec_i.illegal) begin
      rsp_o.result    = `POSIT_ZERO;
      rsp_o.status.nv = 1'b1;
    end else if (sel.lt || sel.le || sel.eq) begin
      rsp_o.result    = cmp_word;
      rsp_o.status.nv = any_nar;
    end else if (sel.max || sel.min) begin
      rsp_o.result    = minmax_word;
      rsp_o.status.nv = any_nar;
    end else begin
      rsp_o.result    = sgnj_word;  // NaR passes without nv here
    end
  end

  // Decode must hand over exactly one variant for a legal request
  // All zeros is the stage register before its first load
  always_comb begin
    if (!$isunknown(dec_i.sel) && !dec_i.illegal && dec_i != '0) begin
      a_sel_onehot : assert ($onehot(dec_i.sel))
        else $error("posit_execute: variant selection not one-hot");
    end
  end

endmodule

/* source/posit_noncomp.sv */
`timescale 1ns/1ps

module posit_noncomp (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  flush_i,
  // Request side
  input  posit_pkg::request_t   req_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  // Response side
  output posit_pkg::response_t  rsp_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic                  busy_o
);

  posit_pkg::decoded_t  dec;
  posit_pkg::response_t exe_rsp;
  logic                 dec_valid;
  logic                 dec_advance;
  logic                 res_load;

  // Stage 1 moves when empty or when stage 2 takes its item
  assign dec_advance = !dec_valid || res_load;
  assign in_ready_o  = dec_advance;  // Flush deliberately not involved

  posit_decode u_decode (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .flush_i   (flush_i),
    .req_i     (req_i),
    .valid_i   (in_valid_i),
    .advance_i (dec_advance),
    .dec_o     (dec),
    .valid_o   (dec_valid)
  );

  posit_execute u_execute (
    .dec_i (dec),
    .rsp_o (exe_rsp)
  );

  posit_result u_result (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (flush_i),
    .rsp_i   (exe_rsp),
    .valid_i (dec_valid),
    .ready_i (out_ready_i),
    .load_o  (res_load),
    .rsp_o   (rsp_o),
    .valid_o (out_valid_o)
  );

  // Anything held in either register
  assign busy_o = dec_valid || out_valid_o;

endmodule

/* source/posit_pkg.sv */
`include "posit_defines.svh"

package posit_pkg;

  typedef enum logic [1:0] {
    CMP     = 2'b00,
    SGNJ    = 2'b01,
    MINMAX  = 2'b10,
    OP_NONE = 2'b11  // Unused, answered as illegal
  } operation_e;

  // Only RNE, RTZ and RDN carry a meaning in this unit
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100,
    ROD = 3'b101,
    DYN = 3'b111
  } roundmode_e;

  typedef enum logic [1:0] {
    SI_SGNJ    = 2'b00,
    SI_SGNJN   = 2'b01,
    SI_SGNJX   = 2'b10,
    SI_ILLEGAL = 2'b11
  } signinject_e;

  typedef struct packed {
    logic nv;  // Invalid operation
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  typedef struct packed {
    logic                     sign;
    logic [`POSIT_WIDTH-2:0]  body;
  } posit_fields_t;

  // Same word seen as a signed integer for ordering or as sign plus body
  typedef union packed {
    logic signed [`POSIT_WIDTH-1:0] ordinal;
    posit_fields_t                  fields;
  } posit_u;

  typedef struct packed {
    posit_u       a;
    posit_u       b;
    operation_e   op;
    roundmode_e   rnd_mode;
    signinject_e  sgnj_mode;
  } request_t;

  // One-hot operation variant
  typedef struct packed {
    logic lt;
    logic le;
    logic eq;
    logic max;
    logic min;
    logic sgnj;
    logic sgnjn;
    logic sgnjx;
  } variant_t;

  typedef struct packed {
    posit_u    a;
    posit_u    b;
    variant_t  sel;
    logic      nar_a;
    logic      nar_b;
    logic      illegal;
  } decoded_t;

  typedef struct packed {
    logic [`POSIT_WIDTH-1:0] result;
    status_t                 status;
  } response_t;

endpackage

/* source/posit_result.sv */
`timescale 1ns/1ps

module posit_result (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  flush_i,
  input  posit_pkg::response_t  rsp_i,
  input  logic                  valid_i,
  input  logic                  ready_i,
  output logic                  load_o,
  output posit_pkg::response_t  rsp_o,
  output logic                  valid_o
);

  posit_pkg::response_t rsp_q;
  logic                 valid_q;

  // Free slot, or the held item leaves this cycle
  assign load_o = !valid_q || ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (load_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_o && valid_i) begin
      rsp_q <= rsp_i;  // Held otherwise
    end
  end

  assign rsp_o   = rsp_q;
  assign valid_o = valid_q;

  // Stalled output keeps both valid and payload
  a_hold_stalled : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (valid_o && !ready_i && !flush_i) |=> (valid_o && $stable(rsp_o))
  );

endmodule

/* verilog.f */
+incdir+source
source/posit_pkg.sv
source/posit_decode.sv
source/posit_execute.sv
source/posit_result.sv
source/posit_noncomp.sv
bench/tb_posit_noncomp.sv
